//--- forwardGolden.txt
# ctl(rst imm lnk br jr) wr(ex exm ld mw wb) exD exR exmD exmR ld mwD mwR wbD wbR rs rsV rt rtV
# brRs brA brRt brB jr jV expBrA expBrB expJump expOpA expOpB expFlags(br jr alu)
00010 11111 01 e1 02 a1 d1 03 b1 04 c1 01 11 02 22 01 33 03 44 04 55 e1 b1 55 00 00 100
00001 11011 05 e1 06 a1 d1 07 b1 08 c1 06 11 07 22 05 33 06 44 06 55 33 44 a1 00 00 010
00000 00000 01 e1 02 a1 d1 03 b1 04 c1 01 11 02 22 01 33 02 44 03 55 33 44 55 00 00 000
10000 11011 09 e1 09 a1 d1 09 b1 09 c1 09 11 0a 22 09 33 09 44 09 55 33 44 55 00 00 000
10010 11011 09 e1 0b a1 d1 09 b1 09 c1 09 11 0a 22 09 33 0b 44 00 55 e1 a1 55 a1 22 101
10011 11011 09 e1 0b a1 d1 0c b1 09 c1 09 11 0a 22 0c 33 0a 44 09 55 b1 44 e1 b1 22 111
10010 11011 09 e1 0b a1 d1 0c b1 0d c1 09 11 0a 22 0d 33 00 44 00 55 c1 44 55 c1 22 101
11000 11011 09 e1 0b a1 d1 0c b1 0d c1 0c 11 0b 22 0b 33 0c 44 0d 55 33 44 55 11 22 000
10101 11111 09 e1 0b a1 d1 0c b1 0d c1 0b 11 0d 22 00 33 00 44 0b 55 33 44 d1 b1 22 011
11110 11111 09 e1 0b a1 d1 0c b1 0d c1 0b 11 0c 22 0b 33 09 44 0c 55 d1 e1 55 11 c1 101
10010 11111 00 e1 0b a1 d1 0c b1 00 c1 0b 11 00 22 00 33 00 44 00 55 33 44 55 11 22 000
10011 00000 09 e1 0b a1 d1 0c b1 0d c1 0c 11 0d 22 09 33 0b 44 0c 55 33 44 55 d1 22 001
10001 11011 01 e1 02 a1 d1 0e b1 0e c1 0e 11 02 22 00 33 00 44 0e 55 33 44 b1 11 22 010
10001 10001 03 e1 0f a1 d1 0f b1 0f c1 0f 11 03 22 00 33 00 44 0f 55 33 44 c1 b1 a1 011
00011 11011 10 e1 11 a1 d1 12 b1 13 c1 10 11 11 22 11 33 12 44 13 55 a1 b1 c1 c1 22 111
10000 00000 01 e1 02 a1 d1 03 b1 04 c1 01 11 02 22 01 33 02 44 03 55 33 44 55 00 00 000
10010 10000 1f 89abcdef 02 a1 d1 03 b1 04 c1 1f 11 1f 22 1f 33 00 44 03 55 89abcdef 44 55 11 22 100

//--- src.f
forwardPkg.sv
bypassBus.sv
operandBypass.sv
aluOperandStage.sv
decodeBypass.sv
forwardTop.sv
forwardTop_tb.sv

//--- runSim.sh
#!/bin/sh
# build with Verilator, run, then decide on the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/1ns -f src.f --top-module forwardTop_tb \
    -o forwardSim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/forwardSim > sim.log 2>&1

grep -q "^Testbench passed$" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL, see sim.log"; exit 1; }

//--- forwardTop_tb.sv
`timescale 1ns/1ns
`default_nettype none

module forwardTop_tb;
    import forwardPkg::*;

    localparam int halfPeriod = 10;
    localparam int resetCycles = 3;
    localparam int slackCycles = 10;
    localparam int lineFields = 27;
    localparam string goldenPath = "forwardGolden.txt";

    logic CLOCK;
    logic RESET;
    regIndexT exDest, exMemDest, memWbDest, wbDest;
    wordT exResult, exMemResult, loadData, memWbResult, wbResult;
    logic exWrite, exMemWrite, exMemLoad, memWbWrite, wbWrite;
    regIndexT rsReg, rtReg, branchRsReg, branchRtReg, jumpReg;
    wordT rsValue, rtValue, branchValueA, branchValueB, jumpValue;
    logic useImmediate, isLink, isBranch, isJumpReg;
    wordT operandA, operandB, branchOperandA, branchOperandB, jumpTarget;
    logic aluForward, branchForward, jumpForward;

    // one golden line held until the next falling edge
    logic [19:0] ctlField;
    logic [19:0] writeField;
    logic [11:0] expFlags;
    regIndexT vecExDest, vecExMemDest, vecMemWbDest, vecWbDest;
    wordT vecExResult, vecExMemResult, vecLoadData, vecMemWbResult, vecWbResult;
    regIndexT vecRsReg, vecRtReg, vecBranchRsReg, vecBranchRtReg, vecJumpReg;
    wordT vecRsValue, vecRtValue, vecBranchValueA, vecBranchValueB, vecJumpValue;
    wordT expBranchA, expBranchB, expJump, expOperandA, expOperandB;

    int goldenFd;
    int fieldCount;
    int lineCount;
    int lineNumber;
    int cycleCount;
    int cycleLimit;

    forwardTop i_forwardTop (.*);

    initial begin
        CLOCK = 1'b0;
        forever begin
            #halfPeriod CLOCK = ~CLOCK;
        end
    end

    task automatic abortRun();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("ERR line %0d %s expected %h actual %h", lineNumber, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR line %0d %s expected %h actual %h", lineNumber, name, expected, actual);
            abortRun();
        end
    endtask

    task automatic openGolden();
        logic [8*128-1:0] headerLine;
        int headerChars;
        goldenFd = $fopen(goldenPath, "r");
        if (goldenFd == 0) begin
            $display("cannot open the golden file %s", goldenPath);
            abortRun();
        end
        // two comment lines name the columns
        headerChars = $fgets(headerLine, goldenFd);
        if (headerChars > 0) begin
            headerChars = $fgets(headerLine, goldenFd);
        end
        if (headerChars == 0) begin
            $display("golden file %s ends before its column header", goldenPath);
            abortRun();
        end
    endtask

    task automatic readRecord();
        fieldCount = $fscanf(goldenFd,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            ctlField, writeField, vecExDest, vecExResult, vecExMemDest, vecExMemResult,
            vecLoadData, vecMemWbDest, vecMemWbResult, vecWbDest, vecWbResult,
            vecRsReg, vecRsValue, vecRtReg, vecRtValue,
            vecBranchRsReg, vecBranchValueA, vecBranchRtReg, vecBranchValueB,
            vecJumpReg, vecJumpValue,
            expBranchA, expBranchB, expJump, expOperandA, expOperandB, expFlags);
    endtask

    task automatic countLines();
        logic atEnd;
        openGolden();
        lineCount = 0;
        readRecord();
        while (fieldCount == lineFields) begin
            lineCount++;
            readRecord();
        end
        atEnd = ($feof(goldenFd) != 0);
        $fclose(goldenFd);
        if (fieldCount > 0 || !atEnd || lineCount == 0) begin
            $display("golden file is short or malformed after %0d complete lines", lineCount);
            abortRun();
        end
    endtask

    task automatic applyLine();
        // each flag is one hex digit of its field
        RESET = ctlField[16];
        useImmediate = ctlField[12];
        isLink = ctlField[8];
        isBranch = ctlField[4];
        isJumpReg = ctlField[0];
        exWrite = writeField[16];
        exMemWrite = writeField[12];
        exMemLoad = writeField[8];
        memWbWrite = writeField[4];
        wbWrite = writeField[0];
        exDest = vecExDest;
        exResult = vecExResult;
        exMemDest = vecExMemDest;
        exMemResult = vecExMemResult;
        loadData = vecLoadData;
        memWbDest = vecMemWbDest;
        memWbResult = vecMemWbResult;
        wbDest = vecWbDest;
        wbResult = vecWbResult;
        rsReg = vecRsReg;
        rsValue = vecRsValue;
        rtReg = vecRtReg;
        rtValue = vecRtValue;
        branchRsReg = vecBranchRsReg;
        branchValueA = vecBranchValueA;
        branchRtReg = vecBranchRtReg;
        branchValueB = vecBranchValueB;
        jumpReg = vecJumpReg;
        jumpValue = vecJumpValue;
    endtask

    task automatic checkDecode();
        checkWord("branchOperandA", expBranchA, branchOperandA);
        checkWord("branchOperandB", expBranchB, branchOperandB);
        checkWord("jumpTarget", expJump, jumpTarget);
        checkFlag("branchForward", expFlags[8], branchForward);
        checkFlag("jumpForward", expFlags[4], jumpForward);
    endtask

    task automatic checkAlu();
        checkWord("operandA", expOperandA, operandA);
        checkWord("operandB", expOperandB, operandB);
        checkFlag("aluForward", expFlags[0], aluForward);
    endtask

    initial begin
        {RESET, exDest, exResult, exWrite, exMemDest, exMemResult, exMemWrite, exMemLoad,
            loadData, memWbDest, memWbResult, memWbWrite, wbDest, wbResult, wbWrite,
            rsReg, rtReg, rsValue, rtValue, useImmediate, isLink, isBranch, isJumpReg,
            branchRsReg, branchRtReg, jumpReg, branchValueA, branchValueB, jumpValue} = '0;
        countLines();
        cycleLimit = lineCount + resetCycles + slackCycles;
        openGolden();
        lineNumber = 0;
        repeat (lineCount) begin
            @(posedge CLOCK);
            #(halfPeriod - 1);
            // decode still shows the line applied at the last falling edge
            if (lineNumber > 0) begin
                checkDecode();
            end
            readRecord();
            lineNumber++;
            // registers hold the previous line's operands until the next rising edge
            checkAlu();
            @(negedge CLOCK);
            applyLine();
        end
        @(posedge CLOCK);
        #(halfPeriod - 1);
        checkDecode();
        $fclose(goldenFd);
        $display("Testbench passed");
        $finish;
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge CLOCK);
            cycleCount++;
            if (cycleCount > cycleLimit) begin
                $display("timeout after %0d cycles before the last golden line", cycleCount);
                abortRun();
            end
        end
    end

endmodule

`default_nettype wire

//--- forwardTop.sv
`timescale 1ns/1ns
`default_nettype none

module forwardTop (
    input logic CLOCK,
    input logic RESET,

    // execute stage
    input forwardPkg::regIndexT exDest,
    input forwardPkg::wordT exResult,
    input logic exWrite,

    // EX/MEM
    input forwardPkg::regIndexT exMemDest,
    input forwardPkg::wordT exMemResult,
    input logic exMemWrite,
    input logic exMemLoad,
    input forwardPkg::wordT loadData,

    // MEM/WB
    input forwardPkg::regIndexT memWbDest,
    input forwardPkg::wordT memWbResult,
    input logic memWbWrite,

    // register file write port
    input forwardPkg::regIndexT wbDest,
    input forwardPkg::wordT wbResult,
    input logic wbWrite,

    // ID/EX operands
    input forwardPkg::regIndexT rsReg,
    input forwardPkg::regIndexT rtReg,
    input forwardPkg::wordT rsValue,
    input forwardPkg::wordT rtValue,
    input logic useImmediate,
    input logic isLink,

    // decode branch and jump register
    input logic isBranch,
    input logic isJumpReg,
    input forwardPkg::regIndexT branchRsReg,
    input forwardPkg::regIndexT branchRtReg,
    input forwardPkg::regIndexT jumpReg,
    input forwardPkg::wordT branchValueA,
    input forwardPkg::wordT branchValueB,
    input forwardPkg::wordT jumpValue,

    output forwardPkg::wordT operandA,
    output forwardPkg::wordT operandB,
    output logic aluForward,
    output forwardPkg::wordT branchOperandA,
    output forwardPkg::wordT branchOperandB,
    output forwardPkg::wordT jumpTarget,
    output logic branchForward,
    output logic jumpForward
);

    bypassBus bus ();

    assign bus.exDest = exDest;
    assign bus.exResult = exResult;
    assign bus.exWrite = exWrite;
    assign bus.exMemDest = exMemDest;
    assign bus.exMemResult = exMemResult;
    assign bus.exMemWrite = exMemWrite;
    assign bus.exMemLoad = exMemLoad;
    assign bus.loadData = loadData;
    assign bus.memWbDest = memWbDest;
    assign bus.memWbResult = memWbResult;
    assign bus.memWbWrite = memWbWrite;
    assign bus.wbDest = wbDest;
    assign bus.wbResult = wbResult;
    assign bus.wbWrite = wbWrite;

    aluOperandStage i_aluOperandStage (
        .CLOCK(CLOCK),
        .RESET(RESET),
        .bus(bus),
        .rsReg(rsReg),
        .rtReg(rtReg),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .useImmediate(useImmediate),
        .isLink(isLink),
        .operandA(operandA),
        .operandB(operandB),
        .aluForward(aluForward)
    );

    // purely combinational, no clock or reset
    decodeBypass i_decodeBypass (
        .bus(bus),
        .isBranch(isBranch),
        .isJumpReg(isJumpReg),
        .branchRsReg(branchRsReg),
        .branchRtReg(branchRtReg),
        .jumpReg(jumpReg),
        .branchValueA(branchValueA),
        .branchValueB(branchValueB),
        .jumpValue(jumpValue),
        .branchOperandA(branchOperandA),
        .branchOperandB(branchOperandB),
        .jumpTarget(jumpTarget),
        .branchForward(branchForward),
        .jumpForward(jumpForward)
    );

endmodule

`default_nettype wire

//--- decodeBypass.sv
`timescale 1ns/1ns
`default_nettype none

module decodeBypass (
    bypassBus.consumer bus,
    input logic isBranch,
    input logic isJumpReg,
    input forwardPkg::regIndexT branchRsReg,
    input forwardPkg::regIndexT branchRtReg,
    input forwardPkg::regIndexT jumpReg,
    input forwardPkg::wordT branchValueA,
    input forwardPkg::wordT branchValueB,
    input forwardPkg::wordT jumpValue,
    output forwardPkg::wordT branchOperandA,
    output forwardPkg::wordT branchOperandB,
    output forwardPkg::wordT jumpTarget,
    output logic branchForward,
    output logic jumpForward
);
    import forwardPkg::*;

    wordT rsBypass;
    wordT rtBypass;
    wordT jumpBypass;
    forwardSourceE rsSource;
    forwardSourceE rtSource;
    forwardSourceE jumpSource;

    // decode sees the execute result in the same cycle
    operandBypass #(
        .useExecute(1'b1)
    ) i_branchRsBypass (
        .bus(bus),
        .srcReg(branchRsReg),
        .regValue(branchValueA),
        .value(rsBypass),
        .source(rsSource)
    );

    operandBypass #(
        .useExecute(1'b1)
    ) i_branchRtBypass (
        .bus(bus),
        .srcReg(branchRtReg),
        .regValue(branchValueB),
        .value(rtBypass),
        .source(rtSource)
    );

    operandBypass #(
        .useExecute(1'b1)
    ) i_jumpBypass (
        .bus(bus),
        .srcReg(jumpReg),
        .regValue(jumpValue),
        .value(jumpBypass),
        .source(jumpSource)
    );

    // comparands only forwarded for a branch
    assign branchOperandA = isBranch ? rsBypass : branchValueA;
    assign branchOperandB = isBranch ? rtBypass : branchValueB;
    assign branchForward = isBranch && ((rsSource != srcRegFile) || (rtSource != srcRegFile));

    // jr/jalr target goes straight to fetch
    assign jumpTarget = isJumpReg ? jumpBypass : jumpValue;
    assign jumpForward = isJumpReg && (jumpSource != srcRegFile);

endmodule

`default_nettype wire

//--- aluOperandStage.sv
`timescale 1ns/1ns
`default_nettype none

module aluOperandStage (
    input logic CLOCK,
    input logic RESET,
    bypassBus.consumer bus,
    input forwardPkg::regIndexT rsReg,
    input forwardPkg::regIndexT rtReg,
    input forwardPkg::wordT rsValue,
    input forwardPkg::wordT rtValue,
    input logic useImmediate,
    input logic isLink,
    output forwardPkg::wordT operandA,
    output forwardPkg::wordT operandB,
    output logic aluForward
);
    import forwardPkg::*;

    wordT rsBypass;
    wordT rtBypass;
    forwardSourceE rsSource;
    forwardSourceE rtSource;
    logic rsKeptForward;
    logic rtKeptForward;

    // the instruction in execute is the consumer, so no execute source here
    operandBypass #(
        .useExecute(1'b0)
    ) i_rsBypass (
        .bus(bus),
        .srcReg(rsReg),
        .regValue(rsValue),
        .value(rsBypass),
        .source(rsSource)
    );

    operandBypass #(
        .useExecute(1'b0)
    ) i_rtBypass (
        .bus(bus),
        .srcReg(rtReg),
        .regValue(rtValue),
        .value(rtBypass),
        .source(rtSource)
    );

    // an overridden operand never counts as forwarded
    assign rsKeptForward = !isLink && (rsSource != srcRegFile);
    assign rtKeptForward = !useImmediate && (rtSource != srcRegFile);

    always_ff @(posedge CLOCK) begin
        if (!RESET) begin
            operandA <= '0;
            operandB <= '0;
            aluForward <= 1'b0;
        end else begin
            // link keeps the return address from decode
            operandA <= isLink ? rsValue : rsBypass;
            // rtValue already holds the immediate
            operandB <= useImmediate ? rtValue : rtBypass;
            aluForward <= rsKeptForward || rtKeptForward;
        end
    end

endmodule

`default_nettype wire

//--- operandBypass.sv
`timescale 1ns/1ns
`default_nettype none

module operandBypass #(
    parameter bit useExecute = 1'b1
) (
    bypassBus.consumer bus,
    input forwardPkg::regIndexT srcReg,
    input forwardPkg::wordT regValue,
    output forwardPkg::wordT value,
    output forwardPkg::forwardSourceE source
);
    import forwardPkg::*;

    logic exHit;
    logic exMemHit;
    logic memWbHit;
    logic wbHit;
    logic isZero;
    wordT exMemValue;

    assign isZero = (srcReg == regIndexT'(zeroReg));

    // a stage only matches when it actually writes
    assign exHit = useExecute && bus.exWrite && (bus.exDest == srcReg);
    assign exMemHit = bus.exMemWrite && (bus.exMemDest == srcReg);
    assign memWbHit = bus.memWbWrite && (bus.memWbDest == srcReg);
    assign wbHit = bus.wbWrite && (bus.wbDest == srcReg);

    // loads have no ALU result yet, data comes from memory
    assign exMemValue = bus.exMemLoad ? bus.loadData : bus.exMemResult;

    always_comb begin
        value = regValue;
        source = srcRegFile;
        if (!isZero) begin
            // newest stage first
            if (exHit) begin
                value = bus.exResult;
                source = srcExecute;
            end else if (exMemHit) begin
                value = exMemValue;
                source = srcExMem;
            end else if (memWbHit) begin
                value = bus.memWbResult;
                source = srcMemWb;
            end else if (wbHit) begin
                value = bus.wbResult;
                source = srcWriteback;
            end
        end
    end

endmodule

`default_nettype wire

//--- bypassBus.sv
`timescale 1ns/1ns
`default_nettype none

interface bypassBus;
    import forwardPkg::*;

    // execute stage
    regIndexT exDest;
    wordT exResult;
    logic exWrite;

    // EX/MEM register, loadData valid when exMemLoad is set
    regIndexT exMemDest;
    wordT exMemResult;
    logic exMemWrite;
    logic exMemLoad;
    wordT loadData;

    // MEM/WB register
    regIndexT memWbDest;
    wordT memWbResult;
    logic memWbWrite;

    // register file write port
    regIndexT wbDest;
    wordT wbResult;
    logic wbWrite;

    modport source (
        output exDest, exResult, exWrite,
        output exMemDest, exMemResult, exMemWrite, exMemLoad, loadData,
        output memWbDest, memWbResult, memWbWrite,
        output wbDest, wbResult, wbWrite
    );

    modport consumer (
        input exDest, exResult, exWrite,
        input exMemDest, exMemResult, exMemWrite, exMemLoad, loadData,
        input memWbDest, memWbResult, memWbWrite,
        input wbDest, wbResult, wbWrite
    );

endinterface

`default_nettype wire

//--- forwardPkg.sv
`default_nettype none

package forwardPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int sourceWidth = 3;

    // $zero reads as zero and is never a forwarding target
    localparam int zeroReg = 0;

    typedef logic [dataWidth-1:0] wordT;
    typedef logic [regAddrWidth-1:0] regIndexT;

    // origin of a selected operand
    typedef enum logic [sourceWidth-1:0] {
        srcRegFile,
        srcExecute,
        srcExMem,
        srcMemWb,
        srcWriteback
    } forwardSourceE;

endpackage

`default_nettype wire
